//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// alu op codes seen by the memory stage
`define ALU_OP_WIDTH    4
`define ALU_ADD         4'd0
`define ALU_CSRRS       4'd11
`define ALU_CSRRW       4'd12
`define ALU_ECALL       4'd13
`define ALU_MRET        4'd14

// load flags, zero means no load
`define LD_W            3'd1
`define LD_D            3'd2
`define LD_B            3'd4
`define LD_H            3'd6

// result extension codes
`define EXP_NONE        4'd0
`define EXP_SW          4'd1
`define EXP_ZW          4'd2
`define EXP_SH          4'd3

// machine mode csr addresses
`define CSR_MSTATUS     12'd768
`define CSR_MIE         12'd772
`define CSR_MTVEC       12'd773
`define CSR_MEPC        12'd833
`define CSR_MCAUSE      12'd834

// clint mmio map
`define CLINT_MTIMECMP  64'h0000_0000_0200_4000
`define CLINT_MTIME     64'h0000_0000_0200_BFF8

// bus requester ids
`define BUS_ID_FETCH    4'd1
`define BUS_ID_LSU      4'd2

`define MSTATUS_RESET   64'h0000_0000_A000_1800

`endif

//--- rv_pkg.sv
package rv_pkg;

    // returned load word, read whole or by lane
    typedef union packed {
        logic [63:0]      d;
        logic [1:0][31:0] w;
        logic [3:0][15:0] h;
        logic [7:0][7:0]  b;
    } ld_data_u;

    // load sequencing states
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        MEM  = 3'd1,
        MMIO = 3'd2,
        EN   = 3'd3,
        FN   = 3'd4
    } lsu_state_e;

endpackage

//--- mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;

    // request side, req is a single cycle strobe
    logic        req;
    logic [63:0] addr;
    logic [3:0]  id;

    // response side, done pulses once with rdata valid
    logic [63:0] rdata;
    logic        done;

    modport requester (
        output req,
        output addr,
        output id,
        input  rdata,
        input  done
    );

    modport arbiter (
        input  req,
        input  addr,
        input  id,
        output rdata,
        output done
    );

endinterface

//--- mem_clint.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_clint (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mmio_rd,
    input  logic [63:0] addr,
    input  logic [63:0] mtimecmp,
    input  logic        irq_enable,
    output logic [63:0] rdata,
    output logic        timer_irq
);

    logic [63:0] mtime;

    // free running, one tick per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // mmio read mux, unmapped addresses read as zero
    always_comb begin
        rdata = 64'd0;
        if (mmio_rd) begin
            case (addr)
                `CLINT_MTIME:    rdata = mtime;
                `CLINT_MTIMECMP: rdata = mtimecmp;
                default:         rdata = 64'd0;
            endcase
        end
    end

    // level interrupt, drops once the core clears MIE on trap entry
    assign timer_irq = irq_enable && (mtime >= mtimecmp);

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_stage
    import rv_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [63:0]              pc,
    input  logic [2:0]               rd_buf_flag,
    input  logic [`ALU_OP_WIDTH-1:0] alu_op,
    input  logic [63:0]              alu_src1,
    input  logic [63:0]              alu_src2,
    input  logic [63:0]              ex_result,
    input  logic [3:0]               expand,
    input  logic [11:0]              csr_addr,
    input  logic [63:0]              mtimecmp,
    output logic [63:0]              wb_result,
    output logic                     res_valid,
    output logic [63:0]              mepc,
    output logic [63:0]              mcause,
    output logic [63:0]              mtvec,
    output logic [63:0]              mstatus,
    output logic [63:0]              mie,
    output logic                     timer_irq,
    mem_bus_if.requester             bus
);

    lsu_state_e  state_q;
    lsu_state_e  state_d;
    logic [63:0] ea;
    logic        is_load;
    logic        is_mmio;
    logic [63:0] addr_q;
    logic [2:0]  flag_q;
    logic [3:0]  exp_q;
    ld_data_u    ld_q;
    logic [63:0] clint_rdata;
    logic [63:0] lane_res;
    logic [63:0] ext_res;
    logic        irq_en;
    logic        csr_we;
    logic [63:0] csr_wdata;

    assign ea      = alu_src1 + alu_src2;
    assign is_load = rd_buf_flag inside {`LD_W, `LD_D, `LD_B, `LD_H};
    assign is_mmio = (ea == `CLINT_MTIMECMP) || (ea == `CLINT_MTIME);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (is_load) begin
                    state_d = is_mmio ? MMIO : MEM;
                end
            end
            MEM:     state_d = EN;
            EN:      state_d = bus.done ? FN : EN;
            MMIO:    state_d = FN;
            FN:      state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // load context is sampled while idle and held to the end of the access
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            addr_q <= ea;
            flag_q <= rd_buf_flag;
            exp_q  <= expand;
        end
        if (state_q == MMIO) begin
            ld_q.d <= clint_rdata;
        end else if (state_q == EN && bus.done) begin
            ld_q.d <= bus.rdata;
        end
    end

    // lane pick by byte offset, little endian
    always_comb begin
        case (flag_q)
            `LD_W:   lane_res = {32'd0, ld_q.w[addr_q[2]]};
            `LD_H:   lane_res = {48'd0, ld_q.h[addr_q[2:1]]};
            `LD_B:   lane_res = {56'd0, ld_q.b[addr_q[2:0]]};
            default: lane_res = ld_q.d;
        endcase
    end

    always_comb begin
        ext_res = lane_res;
        case (exp_q)
            `EXP_SW: ext_res = {{32{lane_res[31]}}, lane_res[31:0]};
            `EXP_ZW: ext_res = {32'd0, lane_res[31:0]};
            `EXP_SH: ext_res = {{48{lane_res[15]}}, lane_res[15:0]};
            default: ;
        endcase
    end

    assign wb_result = (state_q == FN) ? ext_res : ex_result;
    assign res_valid = (state_q == FN);

    assign bus.req  = (state_q == MEM);
    assign bus.addr = addr_q;
    assign bus.id   = `BUS_ID_LSU;

    // global MIE and MTIE together enable the timer
    assign irq_en = mstatus[3] & mie[7];

    mem_clint i_mem_clint (
        .clk        (clk),
        .rst_n      (rst_n),
        .mmio_rd    (state_q == MMIO),
        .addr       (addr_q),
        .mtimecmp   (mtimecmp),
        .irq_enable (irq_en),
        .rdata      (clint_rdata),
        .timer_irq  (timer_irq)
    );

    // alu_src1 carries the csr's current value for csrrs
    assign csr_we    = (alu_op == `ALU_CSRRW) || (alu_op == `ALU_CSRRS);
    assign csr_wdata = (alu_op == `ALU_CSRRS) ? (alu_src1 | alu_src2) : alu_src1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc    <= 64'd0;
            mcause  <= 64'd0;
            mtvec   <= 64'd0;
            mstatus <= `MSTATUS_RESET;
            mie     <= 64'd0;
        end else if (timer_irq) begin
            mepc       <= pc;
            mcause     <= 64'h8000_0000_0000_0007;
            mstatus[7] <= mstatus[3];
            mstatus[3] <= 1'b0;
        end else if (csr_we) begin
            case (csr_addr)
                `CSR_MEPC:    mepc    <= csr_wdata;
                `CSR_MCAUSE:  mcause  <= csr_wdata;
                `CSR_MTVEC:   mtvec   <= csr_wdata;
                `CSR_MSTATUS: mstatus <= csr_wdata;
                `CSR_MIE:     mie     <= csr_wdata;
                default: ;
            endcase
        end else begin
            case (alu_op)
                `ALU_ECALL: begin
                    mepc       <= pc;
                    mcause     <= 64'd11;
                    mstatus[7] <= mstatus[3];
                    mstatus[3] <= 1'b0;
                end
                `ALU_MRET: begin
                    mstatus[3] <= mstatus[7];
                    mstatus[7] <= 1'b1;
                end
                // plain address add, no csr effect
                `ALU_ADD: ;
                default: ;
            endcase
        end
    end

endmodule

//--- fetch_port.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module fetch_port (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         fetch_valid,
    input  logic [63:0]  fetch_pc,
    output logic [31:0]  instr,
    output logic         instr_valid,
    mem_bus_if.requester bus
);

    logic        busy_q;
    logic        req_q;
    logic [63:0] pc_q;
    logic        hi_q;
    logic        accept;

    // new strobes are dropped while a fetch is pending
    assign accept = fetch_valid && !busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            req_q       <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            req_q       <= accept;
            instr_valid <= bus.done;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (bus.done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= {fetch_pc[63:3], 3'b000};
            hi_q <= fetch_pc[2];
        end
        if (bus.done) begin
            instr <= hi_q ? bus.rdata[63:32] : bus.rdata[31:0];
        end
    end

    assign bus.req  = req_q;
    assign bus.addr = pc_q;
    assign bus.id   = `BUS_ID_FETCH;

endmodule

//--- bus_arbiter.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module bus_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    mem_bus_if.arbiter  lsu,
    mem_bus_if.arbiter  ifu,
    output logic        bus_req,
    output logic [63:0] bus_addr,
    output logic [3:0]  bus_id,
    input  logic [63:0] bus_rdata,
    input  logic        bus_done,
    input  logic [3:0]  bus_ret_id
);

    logic pend_lsu_q;
    logic pend_ifu_q;
    logic busy_q;
    logic want_lsu;
    logic want_ifu;
    logic grant_lsu;
    logic grant_ifu;
    logic resp_hit;

    // a strobe in the current cycle counts as pending already
    assign want_lsu  = pend_lsu_q | lsu.req;
    assign want_ifu  = pend_ifu_q | ifu.req;
    assign grant_lsu = !busy_q && want_lsu;
    assign grant_ifu = !busy_q && !want_lsu && want_ifu;

    // only the response tagged with the owner's id closes the transaction
    assign resp_hit = busy_q && bus_done && (bus_ret_id == bus_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_lsu_q <= 1'b0;
            pend_ifu_q <= 1'b0;
            busy_q     <= 1'b0;
            bus_req    <= 1'b0;
            bus_id     <= 4'd0;
        end else begin
            pend_lsu_q <= want_lsu && !grant_lsu;
            pend_ifu_q <= want_ifu && !grant_ifu;
            bus_req    <= grant_lsu || grant_ifu;
            if (grant_lsu || grant_ifu) begin
                busy_q <= 1'b1;
                bus_id <= grant_lsu ? lsu.id : ifu.id;
            end else if (resp_hit) begin
                busy_q <= 1'b0;
            end
        end
    end

    // address is held by the register until the response comes back
    always_ff @(posedge clk) begin
        if (grant_lsu) begin
            bus_addr <= lsu.addr;
        end else if (grant_ifu) begin
            bus_addr <= ifu.addr;
        end
    end

    assign lsu.rdata = bus_rdata;
    assign ifu.rdata = bus_rdata;
    assign lsu.done  = resp_hit && (bus_id == `BUS_ID_LSU);
    assign ifu.done  = resp_hit && (bus_id == `BUS_ID_FETCH);

endmodule

//--- core_mem_top.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module core_mem_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [63:0]              pc,
    input  logic [2:0]               rd_buf_flag,
    input  logic [`ALU_OP_WIDTH-1:0] alu_op,
    input  logic [63:0]              alu_src1,
    input  logic [63:0]              alu_src2,
    input  logic [63:0]              ex_result,
    input  logic [3:0]               expand,
    input  logic [11:0]              csr_addr,
    input  logic [63:0]              mtimecmp,
    output logic [63:0]              wb_result,
    output logic                     res_valid,
    output logic [63:0]              mepc,
    output logic [63:0]              mcause,
    output logic [63:0]              mtvec,
    output logic [63:0]              mstatus,
    output logic [63:0]              mie,
    output logic                     timer_irq,
    input  logic                     fetch_valid,
    input  logic [63:0]              fetch_pc,
    output logic [31:0]              instr,
    output logic                     instr_valid,
    output logic                     bus_req,
    output logic [63:0]              bus_addr,
    output logic [3:0]               bus_id,
    input  logic [63:0]              bus_rdata,
    input  logic                     bus_done,
    input  logic [3:0]               bus_ret_id
);

    mem_bus_if lsu_bus ();
    mem_bus_if ifu_bus ();

    mem_stage i_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .rd_buf_flag (rd_buf_flag),
        .alu_op      (alu_op),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2),
        .ex_result   (ex_result),
        .expand      (expand),
        .csr_addr    (csr_addr),
        .mtimecmp    (mtimecmp),
        .wb_result   (wb_result),
        .res_valid   (res_valid),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtvec       (mtvec),
        .mstatus     (mstatus),
        .mie         (mie),
        .timer_irq   (timer_irq),
        .bus         (lsu_bus)
    );

    fetch_port i_fetch_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .bus         (ifu_bus)
    );

    // load port and fetch share the external bus
    bus_arbiter i_bus_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu        (lsu_bus),
        .ifu        (ifu_bus),
        .bus_req    (bus_req),
        .bus_addr   (bus_addr),
        .bus_id     (bus_id),
        .bus_rdata  (bus_rdata),
        .bus_done   (bus_done),
        .bus_ret_id (bus_ret_id)
    );

endmodule

//--- core_mem_properties.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module core_mem_properties
    import rv_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        bus_req,
    input logic [63:0] bus_addr,
    input logic [3:0]  bus_id,
    input logic        bus_done,
    input logic [3:0]  bus_ret_id,
    input logic        res_valid,
    input lsu_state_e  lsu_state
);

    logic outstanding;

    // one transaction in flight from the req pulse to its matching done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (bus_req) begin
            outstanding <= 1'b1;
        end else if (bus_done && (bus_ret_id == bus_id)) begin
            outstanding <= 1'b0;
        end
    end

    req_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |=> !bus_req)
        else $error("bus_req held high for more than one cycle");

    req_not_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> !outstanding)
        else $error("bus_req issued with a transaction still outstanding");

    addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> $stable(bus_addr))
        else $error("bus_addr changed while a transaction was outstanding");

    res_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |=> !res_valid)
        else $error("res_valid high on two cycles in a row");

    // a load request reaches the bus only while the load FSM waits for it
    lsu_req_in_en: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && (bus_id == `BUS_ID_LSU)) |-> (lsu_state == EN))
        else $error("load request on the bus while the load FSM was not waiting");

endmodule

bind core_mem_top core_mem_properties i_core_mem_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_req    (bus_req),
    .bus_addr   (bus_addr),
    .bus_id     (bus_id),
    .bus_done   (bus_done),
    .bus_ret_id (bus_ret_id),
    .res_valid  (res_valid),
    .lsu_state  (i_mem_stage.state_q)
);

//--- tb_core_mem.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_core_mem;

    // 120 loads at up to 9 cycles each and the short tests stay near 1300 cycles
    localparam int          TIMEOUT_CYCLES = 3000;
    localparam logic [63:0] MEM_PATTERN    = 64'h5A5A_5A5A_0000_0000;

    logic                     clk;
    logic                     rst_n;
    logic [63:0]              pc;
    logic [2:0]               rd_buf_flag;
    logic [`ALU_OP_WIDTH-1:0] alu_op;
    logic [63:0]              alu_src1;
    logic [63:0]              alu_src2;
    logic [63:0]              ex_result;
    logic [3:0]               expand;
    logic [11:0]              csr_addr;
    logic [63:0]              mtimecmp;
    logic [63:0]              wb_result;
    logic                     res_valid;
    logic [63:0]              mepc;
    logic [63:0]              mcause;
    logic [63:0]              mtvec;
    logic [63:0]              mstatus;
    logic [63:0]              mie;
    logic                     timer_irq;
    logic                     fetch_valid;
    logic [63:0]              fetch_pc;
    logic [31:0]              instr;
    logic                     instr_valid;
    logic                     bus_req;
    logic [63:0]              bus_addr;
    logic [3:0]               bus_id;
    logic [63:0]              bus_rdata;
    logic                     bus_done;
    logic [3:0]               bus_ret_id;

    int         cycles;
    logic [7:0] lfsr_state;
    logic [3:0] req_log[$];

    core_mem_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 8 6 5 4 with the new bit entering at bit 0
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // memory answers 2 to 5 cycles after bus_req with data tied to the address
    initial begin : memory_model
        logic [63:0] req_addr;
        logic [3:0]  req_id;
        int          lat;
        bus_done   = 1'b0;
        bus_rdata  = 64'd0;
        bus_ret_id = 4'd0;
        lfsr_state = 8'd20;
        forever begin
            @(negedge clk);
            if (bus_req === 1'b1) begin
                req_addr = bus_addr;
                req_id   = bus_id;
                req_log.push_back(req_id);
                draw_bits(2, lat);
                repeat (lat + 1) @(negedge clk);
                bus_done   = 1'b1;
                bus_rdata  = req_addr ^ MEM_PATTERN;
                bus_ret_id = req_id;
                @(negedge clk);
                bus_done   = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a response never arrived", cycles);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    // lane by byte offset and then extension by the expand code
    function automatic logic [63:0] load_model(input logic [63:0] addr, input logic [2:0] flag,
                                               input logic [3:0] exp_code);
        logic [63:0] word;
        logic [63:0] lane;
        word = addr ^ MEM_PATTERN;
        case (flag)
            `LD_W:   lane = (word >> (32 * addr[2])) & 64'hFFFF_FFFF;
            `LD_H:   lane = (word >> (16 * addr[2:1])) & 64'hFFFF;
            `LD_B:   lane = (word >> (8 * addr[2:0])) & 64'hFF;
            default: lane = word;
        endcase
        case (exp_code)
            `EXP_SW: lane = {{32{lane[31]}}, lane[31:0]};
            `EXP_ZW: lane = {32'd0, lane[31:0]};
            `EXP_SH: lane = {{48{lane[15]}}, lane[15:0]};
            default: lane = lane;
        endcase
        return lane;
    endfunction

    function automatic logic [63:0] csr_value(input logic [11:0] addr);
        case (addr)
            `CSR_MEPC:    return mepc;
            `CSR_MCAUSE:  return mcause;
            `CSR_MTVEC:   return mtvec;
            `CSR_MSTATUS: return mstatus;
            default:      return mie;
        endcase
    endfunction

    task automatic run_load(input string name, input logic [63:0] addr, input logic [2:0] flag,
                            input logic [3:0] exp_code);
        logic [63:0] expected;
        expected = load_model(addr, flag, exp_code);
        @(negedge clk);
        rd_buf_flag = flag;
        alu_src1    = addr - 64'h40;
        alu_src2    = 64'h40;
        expand      = exp_code;
        @(negedge clk);
        rd_buf_flag = 3'd0;
        while (res_valid !== 1'b1) @(negedge clk);
        check_value(name, expected, wb_result);
    endtask

    task automatic mmio_read(input string name, input logic [63:0] addr,
                             output logic [63:0] value, output int at_cycle);
        @(negedge clk);
        rd_buf_flag = `LD_D;
        alu_src1    = addr;
        alu_src2    = 64'd0;
        expand      = `EXP_NONE;
        at_cycle    = cycles;
        @(negedge clk);
        rd_buf_flag = 3'd0;
        @(negedge clk);
        check_value({name, " res_valid timing"}, 64'd1, {63'd0, res_valid});
        value = wb_result;
    endtask

    task automatic csr_op(input logic [3:0] op, input logic [11:0] addr,
                          input logic [63:0] src1, input logic [63:0] src2);
        @(negedge clk);
        alu_op   = op;
        csr_addr = addr;
        alu_src1 = src1;
        alu_src2 = src2;
        @(negedge clk);
        alu_op   = `ALU_ADD;
    endtask

    task automatic no_load_passthrough();
        int start;
        start = req_log.size();
        @(negedge clk);
        ex_result = 64'h1357_9BDF_2468_ACE0;
        @(negedge clk);
        check_value("passthrough a", 64'h1357_9BDF_2468_ACE0, wb_result);
        ex_result = 64'hFEDC_BA98_0000_0042;
        @(negedge clk);
        check_value("passthrough b", 64'hFEDC_BA98_0000_0042, wb_result);
        repeat (4) @(negedge clk);
        check_value("no bus_req without load", 64'(start), 64'(req_log.size()));
    endtask

    task automatic loads_all_widths();
        logic [63:0] bases [2];
        logic [2:0]  flags [4];
        logic [2:0]  fl;
        bit          ok;
        bases[0] = 64'h0000_2000_80F0_7F80;
        bases[1] = 64'hF0E1_D2C3_B4A5_9688;
        flags[0] = `LD_B;
        flags[1] = `LD_H;
        flags[2] = `LD_W;
        flags[3] = `LD_D;
        for (int b = 0; b < 2; b++) begin
            for (int f = 0; f < 4; f++) begin
                fl = flags[f];
                for (int e = 0; e < 4; e++) begin
                    for (int o = 0; o < 8; o++) begin
                        case (fl)
                            `LD_D:   ok = (o == 0);
                            `LD_W:   ok = (o % 4 == 0);
                            `LD_H:   ok = (o % 2 == 0);
                            default: ok = 1'b1;
                        endcase
                        if (ok) begin
                            run_load($sformatf("load flag %0d expand %0d offset %0d", fl, e, o),
                                     bases[b] + 64'(o), fl, 4'(e));
                        end
                    end
                end
            end
        end
    endtask

    task automatic csr_write_and_set();
        logic [11:0] addrs [4];
        logic [63:0] vals [4];
        logic [63:0] mask;
        mask     = 64'h0000_0000_0F00_0001;
        addrs[0] = `CSR_MEPC;
        addrs[1] = `CSR_MCAUSE;
        addrs[2] = `CSR_MTVEC;
        addrs[3] = `CSR_MSTATUS;
        vals[0]  = 64'h0000_0000_8000_1234;
        vals[1]  = 64'h8000_0000_0000_0005;
        vals[2]  = 64'h0000_0000_8000_0100;
        vals[3]  = 64'h0000_000A_0000_1880;
        for (int i = 0; i < 4; i++) begin
            csr_op(`ALU_CSRRW, addrs[i], vals[i], 64'd0);
            check_value($sformatf("csrrw %0d", addrs[i]), vals[i], csr_value(addrs[i]));
            csr_op(`ALU_CSRRS, addrs[i], csr_value(addrs[i]), mask);
            check_value($sformatf("csrrs %0d", addrs[i]), vals[i] | mask, csr_value(addrs[i]));
        end
    endtask

    task automatic ecall_and_mret();
        csr_op(`ALU_CSRRW, `CSR_MSTATUS, 64'h8, 64'd0);
        check_value("mstatus with MIE", 64'h8, mstatus);
        pc = 64'h0000_0000_8000_0A40;
        csr_op(`ALU_ECALL, 12'd0, 64'd0, 64'd0);
        check_value("ecall mepc", 64'h0000_0000_8000_0A40, mepc);
        check_value("ecall mcause", 64'd11, mcause);
        check_value("ecall mstatus", 64'h80, mstatus);
        csr_op(`ALU_MRET, 12'd0, 64'd0, 64'd0);
        check_value("mret mstatus", 64'h88, mstatus);
        // MPIE cleared first so that mret has to set it
        csr_op(`ALU_CSRRW, `CSR_MSTATUS, 64'h8, 64'd0);
        csr_op(`ALU_MRET, 12'd0, 64'd0, 64'd0);
        check_value("mret sets MPIE", 64'h80, mstatus);
        csr_op(`ALU_MRET, 12'd0, 64'd0, 64'd0);
        check_value("mret restores MIE", 64'h88, mstatus);
    endtask

    task automatic clint_and_timer();
        logic [63:0] value;
        logic [63:0] t1;
        logic [63:0] t2;
        int          c1;
        int          c2;
        mtimecmp = 64'h0123_4567_89AB_CDEF;
        mmio_read("mtimecmp read", `CLINT_MTIMECMP, value, c1);
        check_value("mtimecmp read", 64'h0123_4567_89AB_CDEF, value);
        mmio_read("mtime read 1", `CLINT_MTIME, t1, c1);
        repeat (5) @(negedge clk);
        mmio_read("mtime read 2", `CLINT_MTIME, t2, c2);
        check_value("mtime increases", 64'd1, {63'd0, t2 > t1});
        check_value("mtime step", 64'(c2 - c1), t2 - t1);
        // MIE still set from mret so enabling MTIE fires the timer
        mtimecmp = 64'd10;
        pc       = 64'h0000_0000_8000_2040;
        csr_op(`ALU_CSRRW, `CSR_MIE, 64'h80, 64'd0);
        check_value("mie write", 64'h80, mie);
        check_value("timer_irq raised", 64'd1, {63'd0, timer_irq});
        @(negedge clk);
        check_value("timer mcause", 64'h8000_0000_0000_0007, mcause);
        check_value("timer mepc", 64'h0000_0000_8000_2040, mepc);
        check_value("timer mstatus", 64'h80, mstatus);
        check_value("timer_irq cleared", 64'd0, {63'd0, timer_irq});
        mtimecmp = '1;
        csr_op(`ALU_CSRRW, `CSR_MIE, 64'd0, 64'd0);
    endtask

    task automatic fetch_with_load();
        logic [63:0] ld_addr;
        logic [63:0] ld_data;
        logic [31:0] fetched;
        logic [63:0] line;
        int          res_at;
        int          ins_at;
        ld_addr = 64'h0000_0000_9000_0010;
        line    = (64'h0000_0000_8000_0104 & ~64'h7) ^ MEM_PATTERN;
        res_at  = -1;
        ins_at  = -1;
        @(negedge clk);
        fetch_pc    = 64'h0000_0000_8000_0104;
        fetch_valid = 1'b1;
        rd_buf_flag = `LD_D;
        alu_src1    = ld_addr;
        alu_src2    = 64'd0;
        expand      = `EXP_NONE;
        @(negedge clk);
        fetch_valid = 1'b0;
        rd_buf_flag = 3'd0;
        while (res_at < 0 || ins_at < 0) begin
            if (res_valid === 1'b1 && res_at < 0) begin
                res_at  = cycles;
                ld_data = wb_result;
            end
            if (instr_valid === 1'b1 && ins_at < 0) begin
                ins_at  = cycles;
                fetched = instr;
            end
            @(negedge clk);
        end
        check_value("shared load data", ld_addr ^ MEM_PATTERN, ld_data);
        check_value("shared fetch instr", {32'd0, line[63:32]}, {32'd0, fetched});
        check_value("load completes first", 64'd1, {63'd0, res_at < ins_at});
        check_value("first grant id", {60'd0, `BUS_ID_LSU}, {60'd0, req_log[req_log.size() - 2]});
        check_value("second grant id", {60'd0, `BUS_ID_FETCH}, {60'd0, req_log[req_log.size() - 1]});
    endtask

    initial begin
        rst_n       = 1'b0;
        pc          = 64'd0;
        rd_buf_flag = 3'd0;
        alu_op      = `ALU_ADD;
        alu_src1    = 64'd0;
        alu_src2    = 64'd0;
        ex_result   = 64'd0;
        expand      = `EXP_NONE;
        csr_addr    = 12'd0;
        mtimecmp    = '1;
        fetch_valid = 1'b0;
        fetch_pc    = 64'd0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        no_load_passthrough();
        loads_all_widths();
        csr_write_and_set();
        ecall_and_mret();
        clint_and_timer();
        fetch_with_load();
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
rv_pkg.sv
mem_bus_if.sv
mem_clint.sv
mem_stage.sv
fetch_port.sv
bus_arbiter.sv
core_mem_top.sv
core_mem_properties.sv
tb_core_mem.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_core_mem -o tb_core_mem
out=$(./obj_dir/tb_core_mem 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
